//--- Makefile
TOP := layerTb
OBJ := obj_dir

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -Mdir $(OBJ)

run: compile
	./$(OBJ)/V$(TOP)

clean:
	rm -rf $(OBJ)

//--- build.f
+incdir+tb
common/nnPkg.sv
hw/floatMul.sv
hw/floatAdd.sv
hw/neuronUnit.sv
hw/weightArbiter.sv
hw/weightMem.sv
hw/layerTop.sv
tb/layerAssertions.sv
tb/layerTb.sv

//--- common/nnPkg.sv
`default_nettype none

package nnPkg;
	localparam int FLOAT_BITS = 32;

	typedef logic [FLOAT_BITS-1:0] floatT;
	typedef logic [7:0] weightAddrT;  // Neuron id in the upper nibble.
	typedef logic [3:0] termIdxT;  // Term 0 is the bias.

	typedef enum logic [2:0] {
		stIdle,
		stRequest,
		stFetch,
		stAccumulate,
		stFinish
	} neuronStateT;

	typedef struct packed {
		logic req;
		weightAddrT addr;
	} weightReqT;
endpackage

`default_nettype wire

//--- hw/floatAdd.sv
`timescale 1ns/10ps
`default_nettype none

module floatAdd (
	input nnPkg::floatT a,
	input nnPkg::floatT b,
	output nnPkg::floatT sum
);
	logic [30:0] magA;
	logic [30:0] magB;
	logic swap;
	logic signBig;
	logic subtract;
	logic [7:0] expBig;
	logic [7:0] expSmall;
	logic [23:0] sigBig;
	logic [23:0] sigSmall;
	logic [7:0] expDiff;
	logic [4:0] shiftAmt;
	logic [55:0] shifted;
	logic [26:0] aligned;
	logic [27:0] sumRaw;
	logic [4:0] lzc;
	logic [27:0] normSig;
	logic signed [9:0] expRes;

	assign magA = (a[30:23] == 8'd0) ? 31'd0 : a[30:0];  // Subnormals flush.
	assign magB = (b[30:23] == 8'd0) ? 31'd0 : b[30:0];
	assign swap = magB > magA;
	assign signBig = swap ? b[31] : a[31];
	assign subtract = a[31] ^ b[31];

	assign expBig = swap ? magB[30:23] : magA[30:23];
	assign expSmall = swap ? magA[30:23] : magB[30:23];
	assign sigBig = {expBig != 8'd0, swap ? magB[22:0] : magA[22:0]};
	assign sigSmall = {expSmall != 8'd0, swap ? magA[22:0] : magB[22:0]};

	// Shifts past 26 places leave only sticky, so 31 is enough.
	assign expDiff = expBig - expSmall;
	assign shiftAmt = (expDiff > 8'd31) ? 5'd31 : expDiff[4:0];
	assign shifted = {sigSmall, 32'd0} >> shiftAmt;
	assign aligned = {shifted[55:30], |shifted[29:0]};  // Guard, round, sticky.

	assign sumRaw = subtract ? {1'b0, sigBig, 3'd0} - {1'b0, aligned}
		: {1'b0, sigBig, 3'd0} + {1'b0, aligned};

	// Highest set bit wins.
	always_comb
	begin
		lzc = 5'd28;
		for (int i = 0; i < 28; i++)
		begin
			if (sumRaw[i])
				lzc = 5'(27 - i);
		end
	end

	assign normSig = sumRaw << lzc;
	assign expRes = $signed({2'b00, expBig}) + 10'sd1 - $signed({5'd0, lzc});

	always_comb
	begin
		if (sumRaw == 28'd0)
			sum = '0;  // Exact cancellation is +0.
		else if (expRes <= 10'sd0)
			sum = {signBig, 31'd0};
		else if (expRes >= 10'sd255)
			sum = {signBig, 8'hFE, 23'h7FFFFF};
		else
			sum = {signBig, expRes[7:0], normSig[26:4]};  // Truncate.
	end
endmodule

`default_nettype wire

//--- hw/floatMul.sv
`timescale 1ns/10ps
`default_nettype none

module floatMul (
	input nnPkg::floatT a,
	input nnPkg::floatT b,
	output nnPkg::floatT product
);
	logic sign;
	logic [7:0] expA;
	logic [7:0] expB;
	logic [23:0] sigA;
	logic [23:0] sigB;
	logic [47:0] sigProd;
	logic signed [9:0] expSum;
	logic signed [9:0] expNorm;
	logic [22:0] frac;

	assign sign = a[31] ^ b[31];
	assign expA = a[30:23];
	assign expB = b[30:23];
	assign sigA = {1'b1, a[22:0]};
	assign sigB = {1'b1, b[22:0]};
	assign sigProd = sigA * sigB;
	assign expSum = $signed({2'b00, expA}) + $signed({2'b00, expB}) - 10'sd127;

	// Product of two values in [1,2) needs at most one right shift.
	always_comb
	begin
		if (sigProd[47])
		begin
			frac = sigProd[46:24];
			expNorm = expSum + 10'sd1;
		end
		else
		begin
			frac = sigProd[45:23];
			expNorm = expSum;
		end
	end

	always_comb
	begin
		if (expA == 8'd0 || expB == 8'd0)
			product = {sign, 31'd0};  // Subnormal or zero operand.
		else if (expNorm <= 10'sd0)
			product = {sign, 31'd0};  // Underflow flushes.
		else if (expNorm >= 10'sd255)
			product = {sign, 8'hFE, 23'h7FFFFF};  // Largest finite.
		else
			product = {sign, expNorm[7:0], frac};
	end
endmodule

`default_nettype wire

//--- hw/layerTop.sv
`timescale 1ns/10ps
`default_nettype none

module layerTop #(
	parameter int NEURONS = 4,
	parameter int INPUTS = 15
) (
	input logic clk,
	input logic rstN,
	input logic start,
	input nnPkg::floatT [INPUTS-1:0] inputs,
	input logic wrEn,
	input nnPkg::weightAddrT wrAddr,
	input nnPkg::floatT wrData,
	output logic busy,
	output logic done,
	output nnPkg::floatT [NEURONS-1:0] outputs
);
	localparam int DEPTH = NEURONS * 16;

	logic startGated;
	nnPkg::weightReqT [NEURONS-1:0] reqs;
	logic [NEURONS-1:0] grants;
	logic [NEURONS-1:0] unitDone;
	logic [NEURONS-1:0] doneSticky;
	logic allDone;
	nnPkg::weightAddrT rdAddr;
	logic rdEn;
	nnPkg::floatT rdData;

	assign startGated = start && !busy;
	assign allDone = &(doneSticky | unitDone);

	for (genvar n = 0; n < NEURONS; n++)
	begin : gNeuron
		neuronUnit #(
			.INPUTS(INPUTS),
			.NEURON_ID(n)
		) neuron_i (
			.clk(clk),
			.rstN(rstN),
			.start(startGated),
			.inputs(inputs),
			.req(reqs[n]),
			.grant(grants[n]),
			.rdData(rdData),
			.activation(outputs[n]),
			.done(unitDone[n])
		);
	end

	weightArbiter #(
		.NEURONS(NEURONS)
	) arbiter_i (
		.clk(clk),
		.rstN(rstN),
		.reqs(reqs),
		.grants(grants),
		.rdAddr(rdAddr),
		.rdEn(rdEn)
	);

	weightMem #(
		.DEPTH(DEPTH)
	) mem_i (
		.clk(clk),
		.wrEn(wrEn),
		.wrAddr(wrAddr),
		.wrData(wrData),
		.rdEn(rdEn),
		.rdAddr(rdAddr),
		.rdData(rdData)
	);

	// Busy stays up through the done cycle.
	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			busy <= 1'b0;
			done <= 1'b0;
			doneSticky <= '0;
		end
		else
		begin
			done <= 1'b0;
			if (done)
				busy <= 1'b0;
			else if (startGated)
			begin
				busy <= 1'b1;
				doneSticky <= '0;
			end
			else if (busy && allDone)
			begin
				done <= 1'b1;  // Last unit finished.
				doneSticky <= '0;
			end
			else
				doneSticky <= doneSticky | unitDone;
		end
	end
endmodule

`default_nettype wire

//--- hw/neuronUnit.sv
`timescale 1ns/10ps
`default_nettype none

module neuronUnit #(
	parameter int INPUTS = 15,
	parameter int NEURON_ID = 0
) (
	input logic clk,
	input logic rstN,
	input logic start,
	input nnPkg::floatT [INPUTS-1:0] inputs,
	output nnPkg::weightReqT req,
	input logic grant,
	input nnPkg::floatT rdData,
	output nnPkg::floatT activation,
	output logic done
);
	localparam nnPkg::termIdxT LAST_TERM = nnPkg::termIdxT'(INPUTS);

	nnPkg::neuronStateT state;
	nnPkg::termIdxT term;
	nnPkg::floatT weight;
	nnPkg::floatT acc;
	nnPkg::floatT product;
	nnPkg::floatT addSum;
	nnPkg::floatT [INPUTS:0] terms;

	// Slot 0 lines up with the bias term.
	assign terms = {inputs, nnPkg::floatT'(0)};

	floatMul mul_i (
		.a(terms[term]),
		.b(weight),
		.product(product)
	);

	floatAdd add_i (
		.a(acc),
		.b(product),
		.sum(addSum)
	);

	assign req.req = (state == nnPkg::stRequest);
	assign req.addr = {4'(NEURON_ID), term};
	assign done = (state == nnPkg::stFinish);

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			state <= nnPkg::stIdle;
			term <= '0;
			activation <= '0;
		end
		else
		begin
			case (state)
				nnPkg::stIdle:
					if (start)
					begin
						term <= '0;
						state <= nnPkg::stRequest;
					end
				nnPkg::stRequest:
					if (grant)
						state <= nnPkg::stFetch;  // Read issued this cycle.
				nnPkg::stFetch:
					state <= nnPkg::stAccumulate;
				nnPkg::stAccumulate:
					if (term == LAST_TERM)
						state <= nnPkg::stFinish;
					else
					begin
						term <= term + 4'd1;
						state <= nnPkg::stRequest;
					end
				nnPkg::stFinish:
				begin
					activation <= acc[nnPkg::FLOAT_BITS-1] ? '0 : acc;  // Rectifier.
					state <= nnPkg::stIdle;
				end
				default:
					state <= nnPkg::stIdle;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == nnPkg::stFetch)
			weight <= rdData;
		if (state == nnPkg::stAccumulate)
			acc <= (term == 4'd0) ? weight : addSum;  // Bias skips the multiply.
	end
endmodule

`default_nettype wire

//--- hw/weightArbiter.sv
`timescale 1ns/10ps
`default_nettype none

module weightArbiter #(
	parameter int NEURONS = 4
) (
	input logic clk,
	input logic rstN,
	input nnPkg::weightReqT [NEURONS-1:0] reqs,
	output logic [NEURONS-1:0] grants,
	output nnPkg::weightAddrT rdAddr,
	output logic rdEn
);
	localparam int PTR_BITS = (NEURONS > 1) ? $clog2(NEURONS) : 1;

	logic [PTR_BITS-1:0] lastGrant;
	logic [PTR_BITS-1:0] grantIdx;

	// Search starts one past the last winner.
	always_comb
	begin
		logic found;
		logic [PTR_BITS-1:0] idx;
		found = 1'b0;
		grants = '0;
		rdAddr = '0;
		grantIdx = lastGrant;
		for (int i = 1; i <= NEURONS; i++)
		begin
			idx = PTR_BITS'((int'(lastGrant) + i) % NEURONS);
			if (!found && reqs[idx].req)
			begin
				found = 1'b1;
				grants[idx] = 1'b1;
				rdAddr = reqs[idx].addr;
				grantIdx = idx;
			end
		end
	end

	assign rdEn = |grants;

	always_ff @(posedge clk)
	begin
		if (!rstN)
			lastGrant <= PTR_BITS'(NEURONS - 1);  // Unit 0 goes first.
		else if (rdEn)
			lastGrant <= grantIdx;
	end
endmodule

`default_nettype wire

//--- hw/weightMem.sv
`timescale 1ns/10ps
`default_nettype none

module weightMem #(
	parameter int DEPTH = 64
) (
	input logic clk,
	input logic wrEn,
	input nnPkg::weightAddrT wrAddr,
	input nnPkg::floatT wrData,
	input logic rdEn,
	input nnPkg::weightAddrT rdAddr,
	output nnPkg::floatT rdData
);
	localparam int ADDR_BITS = $clog2(DEPTH);

	nnPkg::floatT mem [DEPTH];

	always_ff @(posedge clk)
	begin
		if (wrEn)
			mem[wrAddr[ADDR_BITS-1:0]] <= wrData;
		if (rdEn)
			rdData <= mem[rdAddr[ADDR_BITS-1:0]];  // Valid the next cycle.
	end
endmodule

`default_nettype wire

//--- tb/layerAssertions.sv
`timescale 1ns/10ps
`default_nettype none

module layerAssertions #(
	parameter int NEURONS = 4
) (
	input logic clk,
	input logic rstN,
	input nnPkg::weightReqT [NEURONS-1:0] reqs,
	input logic [NEURONS-1:0] grants,
	input logic done,
	input logic busy
);
	logic [NEURONS-1:0] reqBits;

	always_comb
	begin
		for (int i = 0; i < NEURONS; i++)
			reqBits[i] = reqs[i].req;
	end

	grantOneHot: assert property (@(posedge clk) disable iff (!rstN) $onehot0(grants))
		else $error("grant vector is not one-hot");

	grantToRequester: assert property (@(posedge clk) disable iff (!rstN)
		(grants & ~reqBits) == '0)
		else $error("grant given to a unit without a request");

	donePulse: assert property (@(posedge clk) disable iff (!rstN) done |=> !done)
		else $error("done high in two consecutive cycles");

	busyAfterDone: assert property (@(posedge clk) disable iff (!rstN) done |=> !busy)
		else $error("busy still high in the cycle after done");
endmodule

`default_nettype wire

//--- tb/fpModel.svh
`ifndef FP_MODEL_SVH
`define FP_MODEL_SVH

// Single word widened to a double. Subnormals become signed zero.
function automatic real floatToReal(input nnPkg::floatT f);
	logic [63:0] bits;
	if (f[30:23] == 8'd0)
		bits = {f[31], 63'd0};
	else
		bits = {f[31], 11'(f[30:23]) + 11'd896, f[22:0], 29'd0};  // Bias 1023 - 127.
	return $bitstoreal(bits);
endfunction

// Drops the low mantissa bits of a double, so the result goes toward zero.
function automatic nnPkg::floatT realToFloat(input real r);
	logic [63:0] bits;
	int expS;
	bits = $realtobits(r);
	expS = int'(bits[62:52]) - 896;
	if (expS <= 0)
		return {bits[63], 31'd0};
	else if (expS >= 255)
		return {bits[63], 8'hFE, 23'h7FFFFF};  // Largest finite.
	return {bits[63], 8'(expS), bits[51:29]};
endfunction

// A 24 by 24 bit product is exact in a double.
function automatic nnPkg::floatT mulTrunc(input nnPkg::floatT a, input nnPkg::floatT b);
	return realToFloat(floatToReal(a) * floatToReal(b));
endfunction

// The two-sum error term tells whether the exact sum lies below a representable double.
function automatic nnPkg::floatT addTrunc(input nnPkg::floatT a, input nnPkg::floatT b);
	real x;
	real y;
	real s;
	real bv;
	real err;
	nnPkg::floatT t;
	x = floatToReal(a);
	y = floatToReal(b);
	s = x + y;
	if (s == 0.0)
		return 32'd0;  // Exact cancellation.
	bv = s - x;
	err = (x - (s - bv)) + (y - bv);
	t = realToFloat(s);
	if (err != 0.0 && floatToReal(t) == s && ((err < 0.0) != (s < 0.0)))
	begin
		t[30:0] = t[30:0] - 31'd1;  // One step toward zero.
		if (t[30:23] == 8'd0)
			t[30:0] = 31'd0;
	end
	return t;
endfunction

function automatic nnPkg::floatT rectify(input nnPkg::floatT f);
	return f[31] ? 32'd0 : f;
endfunction

`endif

//--- tb/layerTb.sv
`timescale 1ns/10ps
`default_nettype none

module layerTb;
	localparam int NEURONS = 4;
	localparam int INPUTS = 15;
	localparam int DEPTH = NEURONS * 16;
	localparam int DONE_TIMEOUT = 400;

	logic clk;
	logic rstN;
	logic start;
	nnPkg::floatT [INPUTS-1:0] inputs;
	logic wrEn;
	nnPkg::weightAddrT wrAddr;
	nnPkg::floatT wrData;
	logic busy;
	logic done;
	nnPkg::floatT [NEURONS-1:0] outputs;

	nnPkg::floatT weightImage [DEPTH];
	nnPkg::floatT expected [NEURONS];

	`include "fpModel.svh"

	layerTop #(
		.NEURONS(NEURONS),
		.INPUTS(INPUTS)
	) dut_i (
		.clk(clk),
		.rstN(rstN),
		.start(start),
		.inputs(inputs),
		.wrEn(wrEn),
		.wrAddr(wrAddr),
		.wrData(wrData),
		.busy(busy),
		.done(done),
		.outputs(outputs)
	);

	bind layerTop layerAssertions #(
		.NEURONS(NEURONS)
	) assertions_i (
		.clk(clk),
		.rstN(rstN),
		.reqs(reqs),
		.grants(grants),
		.done(done),
		.busy(busy)
	);

	always #4 clk = ~clk;

	task automatic tick();
		@(posedge clk);
		#1;  // Drive and sample just after the edge.
	endtask

	task automatic failRun(input string why);
		$display("%s", why);
		$display("*** TEST FAILED ***");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic checkValue(input logic [31:0] want, input logic [31:0] got, input string what);
		if (got !== want)
			failRun($sformatf("mismatch at %0t: %s, expected %h, got %h", $time, what, want, got));
	endtask

	function automatic nnPkg::floatT randomFloat(input bit negative);
		return {negative, 8'(100 + $urandom % 51), 23'($urandom)};  // Normal and finite.
	endfunction

	// Mode 0 random, 1 all sums negative, 2 bias cancelled exactly.
	task automatic prepareRound(input int mode);
		int base;
		for (int i = 0; i < INPUTS; i++)
			inputs[i] = randomFloat(mode == 1 ? 1'b0 : 1'($urandom));
		for (int n = 0; n < NEURONS; n++)
		begin
			base = n * 16;
			for (int t = 0; t < 16; t++)
			begin
				if (mode == 0)
					weightImage[base + t] = randomFloat(1'($urandom));
				else if (mode == 1)
					weightImage[base + t] = randomFloat(1'b1);
				else
					weightImage[base + t] = 32'd0;
			end
			if (mode == 2)
			begin
				weightImage[base] = randomFloat(1'($urandom));
				weightImage[base + 1] = weightImage[base] ^ 32'h80000000;
			end
		end
		if (mode == 2)
			inputs[0] = 32'h3F800000;  // One.
	endtask

	task automatic loadMemory();
		for (int a = 0; a < DEPTH; a++)
		begin
			wrEn = 1'b1;
			wrAddr = nnPkg::weightAddrT'(a);
			wrData = weightImage[a];
			tick();
			for (int n = 0; n < NEURONS; n++)
				checkValue(expected[n], outputs[n], $sformatf("held output %0d", n));
		end
		wrEn = 1'b0;
	endtask

	task automatic computeExpected();
		nnPkg::floatT acc;
		for (int n = 0; n < NEURONS; n++)
		begin
			acc = weightImage[n * 16];  // Bias first.
			for (int i = 0; i < INPUTS; i++)
				acc = addTrunc(acc, mulTrunc(inputs[i], weightImage[n * 16 + i + 1]));
			expected[n] = rectify(acc);
		end
	endtask

	task automatic runLayer(input bit pulseAgain);
		int cycles;
		cycles = 0;
		start = 1'b1;
		tick();
		start = 1'b0;
		checkValue(32'd1, 32'(busy), "busy after start");
		while (!done)
		begin
			if (cycles == DONE_TIMEOUT)
				failRun("timeout: done never came after start");
			start = pulseAgain && (cycles % 2 == 1);  // Must be ignored.
			tick();
			cycles++;
		end
		start = 1'b0;
		for (int n = 0; n < NEURONS; n++)
			checkValue(expected[n], outputs[n], $sformatf("output %0d", n));
		for (int c = 0; c < 60; c++)
		begin
			tick();
			checkValue(32'd0, 32'(done), "done after its pulse");
			checkValue(32'd0, 32'(busy), "busy after done");
		end
	endtask

	task automatic runRound(input int mode, input bit pulseAgain);
		prepareRound(mode);
		loadMemory();
		computeExpected();
		runLayer(pulseAgain);
		if (mode != 0)
			for (int n = 0; n < NEURONS; n++)
				checkValue(32'd0, outputs[n], $sformatf("rectified output %0d", n));
	endtask

	initial
	begin
		void'($urandom(25613));
		clk = 1'b0;
		rstN = 1'b0;
		start = 1'b0;
		inputs = '0;
		wrEn = 1'b0;
		wrAddr = '0;
		wrData = '0;
		for (int n = 0; n < NEURONS; n++)
			expected[n] = '0;
		repeat (10) @(posedge clk);
		#1;
		rstN = 1'b1;
		checkValue(32'd0, 32'(busy), "busy after reset");
		checkValue(32'd0, 32'(done), "done after reset");
		for (int n = 0; n < NEURONS; n++)
			checkValue(32'd0, outputs[n], $sformatf("output %0d after reset", n));
		for (int r = 0; r < 20; r++)
			runRound(0, 1'b0);
		runRound(1, 1'b0);
		runRound(2, 1'b0);
		runRound(0, 1'b1);
		$display("*** TEST PASSED ***");
		$finish;
	end
endmodule

`default_nettype wire
